//--- design/fft4_pkg.sv
`default_nettype none

package fft4_pkg;

    // --------------------
    // datapath types
    // --------------------
    typedef logic signed [15:0] sample_t;   // q1.15 real or imag part
    typedef logic signed [31:0] prod_t;     // products, aligned xp, sums

    // re in the upper half so a bus word is one sample
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    localparam sample_t TW_UNITY_RE = 16'sd32767;   // +1.0 in q1.15

    // --------------------
    // wishbone classic
    // --------------------
    typedef logic [3:0]  wb_adr_t;   // word address
    typedef logic [31:0] wb_dat_t;   // full word, no byte selects

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;    // write data
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;    // read data, zero outside ack
    } wb_rsp_t;

    // register map
    localparam wb_adr_t ADDR_X0   = 4'd0;
    localparam wb_adr_t ADDR_X1   = 4'd1;
    localparam wb_adr_t ADDR_X2   = 4'd2;
    localparam wb_adr_t ADDR_X3   = 4'd3;
    localparam wb_adr_t ADDR_CTRL = 4'd4;    // bit 0 starts a transform
    localparam wb_adr_t ADDR_STAT = 4'd5;    // bit 0 busy, bit 1 done
    localparam wb_adr_t ADDR_Y0   = 4'd8;
    localparam wb_adr_t ADDR_Y1   = 4'd9;
    localparam wb_adr_t ADDR_Y2   = 4'd10;
    localparam wb_adr_t ADDR_Y3   = 4'd11;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,     // transform in flight
        S_DONE     // results held until next start
    } fft_state_t;

endpackage

`default_nettype wire

//--- design/butterfly.sv
`default_nettype none

module butterfly #(
    parameter fft4_pkg::sample_t TW_RE = fft4_pkg::TW_UNITY_RE,  // twiddle, real part
    parameter fft4_pkg::sample_t TW_IM = '0                       // twiddle, imag part
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            en,     // operands valid this cycle
    input  wire fft4_pkg::cplx_t xp,
    input  wire fft4_pkg::cplx_t xq,
    output logic                 vld,    // yp/yq valid, 3 cycles after en
    output fft4_pkg::cplx_t      yp,     // (xp + xq*w) / 2
    output fft4_pkg::cplx_t      yq      // (xp - xq*w) / 2
);
    import fft4_pkg::*;

    // --------------------
    // enable shift
    // --------------------
    logic [2:0] en_r;   // bit n enables stage n+2

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_r <= '0;
        end else begin
            en_r <= {en_r[1:0], en};
        end
    end

    assign vld = en_r[2];   // stage 3 holds a fresh result

    // --------------------
    // stage 1, products
    // --------------------
    prod_t pr_rr;   // xq.re * w.re
    prod_t pr_ii;   // xq.im * w.im
    prod_t pr_ri;   // xq.re * w.im
    prod_t pr_ir;   // xq.im * w.re
    prod_t xp_re_s1;
    prod_t xp_im_s1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pr_rr    <= '0;
            pr_ii    <= '0;
            pr_ri    <= '0;
            pr_ir    <= '0;
            xp_re_s1 <= '0;
            xp_im_s1 <= '0;
        end else if (en) begin
            pr_rr    <= prod_t'(xq.re) * prod_t'(TW_RE);
            pr_ii    <= prod_t'(xq.im) * prod_t'(TW_IM);
            pr_ri    <= prod_t'(xq.re) * prod_t'(TW_IM);
            pr_ir    <= prod_t'(xq.im) * prod_t'(TW_RE);
            xp_re_s1 <= prod_t'(xp.re) <<< 15;   // same scale as q1.15 product
            xp_im_s1 <= prod_t'(xp.im) <<< 15;
        end
    end

    // --------------------
    // stage 2, xq * w
    // --------------------
    prod_t xqw_re;
    prod_t xqw_im;
    prod_t xp_re_s2;    // xp delayed to line up
    prod_t xp_im_s2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xqw_re   <= '0;
            xqw_im   <= '0;
            xp_re_s2 <= '0;
            xp_im_s2 <= '0;
        end else if (en_r[0]) begin
            xqw_re   <= pr_rr - pr_ii;   // real part of complex product
            xqw_im   <= pr_ri + pr_ir;   // imag part
            xp_re_s2 <= xp_re_s1;
            xp_im_s2 <= xp_im_s1;
        end
    end

    // --------------------
    // stage 3, add / sub
    // --------------------
    prod_t yp_re_r;
    prod_t yp_im_r;
    prod_t yq_re_r;
    prod_t yq_im_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            yp_re_r <= '0;
            yp_im_r <= '0;
            yq_re_r <= '0;
            yq_im_r <= '0;
        end else if (en_r[1]) begin
            yp_re_r <= xp_re_s2 + xqw_re;    // wraps, no saturation
            yp_im_r <= xp_im_s2 + xqw_im;
            yq_re_r <= xp_re_s2 - xqw_re;
            yq_im_r <= xp_im_s2 - xqw_im;
        end
    end

    // >>> 16 then low 16 bits, i.e. one half per stage
    assign yp = '{re: yp_re_r[31:16], im: yp_im_r[31:16]};
    assign yq = '{re: yq_re_r[31:16], im: yq_im_r[31:16]};

    // --------------------
    // checks
    // --------------------
    // every result traces back to an en three cycles before
    a_vld_after_en: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(vld) |-> $past(en, 3));

    a_vld_low_in_reset: assert property (@(posedge clk) !rst_n |-> !vld);

endmodule

`default_nettype wire

//--- design/fft4_wb_regs.sv
`default_nettype none

module fft4_wb_regs (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire fft4_pkg::wb_req_t wb_req,
    output fft4_pkg::wb_rsp_t      wb_rsp,
    output logic                   en,       // start pulse to first stage
    output fft4_pkg::cplx_t        x0,
    output fft4_pkg::cplx_t        x1,
    output fft4_pkg::cplx_t        x2,
    output fft4_pkg::cplx_t        x3,
    input  wire fft4_pkg::cplx_t   y0,
    input  wire fft4_pkg::cplx_t   y1,
    input  wire fft4_pkg::cplx_t   y2,
    input  wire fft4_pkg::cplx_t   y3,
    input  wire logic              res_vld   // second stage done
);
    import fft4_pkg::*;

    fft_state_t state;
    logic       ack_r;
    wb_dat_t    rd_r;        // read data, only nonzero with ack
    wb_dat_t    rd_mux;
    wb_dat_t    stat_word;
    cplx_t      x_r [4];     // input samples
    cplx_t      y_r [4];     // captured results
    logic       wr_acc;      // write committed this edge
    logic       start_acc;   // start accepted this edge

    // --------------------
    // bus handshake
    // --------------------
    // one ack per access, one cycle after cyc & stb
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_r <= 1'b0;
            rd_r  <= '0;
        end else if (wb_req.cyc && wb_req.stb && !ack_r) begin
            ack_r <= 1'b1;
            rd_r  <= wb_req.we ? '0 : rd_mux;
        end else begin
            ack_r <= 1'b0;
            rd_r  <= '0;
        end
    end

    assign wb_rsp = '{ack: ack_r, dat: rd_r};

    // master still holds the request while ack is up
    assign wr_acc    = wb_req.cyc && wb_req.stb && wb_req.we && ack_r;
    assign start_acc = wr_acc && (wb_req.adr == ADDR_CTRL) && wb_req.dat[0]
                       && (state != S_RUN);     // start while busy dropped
    assign en        = start_acc;

    // --------------------
    // sample registers
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                x_r[i] <= '0;
            end
        end else if (wr_acc && (wb_req.adr <= ADDR_X3)) begin
            x_r[wb_req.adr[1:0]] <= wb_req.dat;  // re in [31:16]
        end
    end

    assign x0 = x_r[0];
    assign x1 = x_r[1];
    assign x2 = x_r[2];
    assign x3 = x_r[3];

    // result capture, held until the next transform lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                y_r[i] <= '0;
            end
        end else if (res_vld) begin
            y_r[0] <= y0;
            y_r[1] <= y1;
            y_r[2] <= y2;
            y_r[3] <= y3;
        end
    end

    // --------------------
    // sequencer
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (start_acc) begin
                        state <= S_RUN;     // also clears done
                    end
                end
                S_RUN: begin
                    if (res_vld) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign stat_word = {30'b0, state == S_DONE, state == S_RUN};  // done, busy

    // read mux, sampled into rd_r with the ack
    always_comb begin
        case (wb_req.adr)
            ADDR_X0:   rd_mux = x_r[0];
            ADDR_X1:   rd_mux = x_r[1];
            ADDR_X2:   rd_mux = x_r[2];
            ADDR_X3:   rd_mux = x_r[3];
            ADDR_STAT: rd_mux = stat_word;
            ADDR_Y0:   rd_mux = y_r[0];
            ADDR_Y1:   rd_mux = y_r[1];
            ADDR_Y2:   rd_mux = y_r[2];
            ADDR_Y3:   rd_mux = y_r[3];
            default:   rd_mux = '0;     // ctrl and holes read zero
        endcase
    end

    // --------------------
    // checks
    // --------------------
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        ack_r |=> !ack_r);

    // datapath result only expected while a transform runs
    a_res_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        res_vld |-> state == S_RUN);

    a_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        en |=> !en);

endmodule

`default_nettype wire

//--- design/fft4_top.sv
`default_nettype none

module fft4_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire fft4_pkg::wb_req_t wb_req,
    output fft4_pkg::wb_rsp_t      wb_rsp
);
    import fft4_pkg::*;

    localparam sample_t TW_ZERO    = '0;
    localparam sample_t TW_NEG_ONE = -TW_UNITY_RE;   // imag part of -j

    logic  en;          // start pulse into stage 1
    cplx_t x0;
    cplx_t x1;
    cplx_t x2;
    cplx_t x3;
    logic  s1_vld;      // stage 1 done, starts stage 2
    cplx_t s1e_yp;      // x0 + x2
    cplx_t s1e_yq;      // x0 - x2
    cplx_t s1o_yp;      // x1 + x3
    cplx_t s1o_yq;      // x1 - x3
    logic  res_vld;
    cplx_t y0;
    cplx_t y1;
    cplx_t y2;
    cplx_t y3;

    fft4_wb_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .en      (en),
        .x0      (x0),
        .x1      (x1),
        .x2      (x2),
        .x3      (x3),
        .y0      (y0),
        .y1      (y1),
        .y2      (y2),
        .y3      (y3),
        .res_vld (res_vld)
    );

    // --------------------
    // stage 1, parallel
    // --------------------
    butterfly #(.TW_RE(TW_UNITY_RE), .TW_IM(TW_ZERO)) bf_s1_even (
        .clk (clk), .rst_n (rst_n), .en (en),
        .xp  (x0), .xq (x2),
        .vld (s1_vld), .yp (s1e_yp), .yq (s1e_yq)
    );

    // runs in lockstep with the even lane, its vld is not needed
    butterfly #(.TW_RE(TW_UNITY_RE), .TW_IM(TW_ZERO)) bf_s1_odd (
        .clk (clk), .rst_n (rst_n), .en (en),
        .xp  (x1), .xq (x3),
        .vld (), .yp (s1o_yp), .yq (s1o_yq)
    );

    // --------------------
    // stage 2, combining
    // --------------------
    butterfly #(.TW_RE(TW_UNITY_RE), .TW_IM(TW_ZERO)) bf_s2_lo (
        .clk (clk), .rst_n (rst_n), .en (s1_vld),
        .xp  (s1e_yp), .xq (s1o_yp),
        .vld (res_vld), .yp (y0), .yq (y2)     // bins 0 and 2
    );

    // w = -j rotates the odd difference
    butterfly #(.TW_RE(TW_ZERO), .TW_IM(TW_NEG_ONE)) bf_s2_hi (
        .clk (clk), .rst_n (rst_n), .en (s1_vld),
        .xp  (s1e_yq), .xq (s1o_yq),
        .vld (), .yp (y1), .yq (y3)            // bins 1 and 3
    );

endmodule

`default_nettype wire

//--- sim/fft4_tb.sv
`default_nettype none

module fft4_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fft4_pkg::*;

    localparam int      ACK_TIMEOUT = 20;     // cycles allowed for one ack
    localparam int      POLL_LIMIT  = 40;     // stat reads before giving up
    localparam string   TEST_FILE   = "sim/fft4_tests.txt";
    localparam wb_adr_t HOLES [6]   = '{4'd6, 4'd7, 4'd12, 4'd13, 4'd14, 4'd15};

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    int      err_cnt;      // failed checks, whole run
    int      test_errs;    // err_cnt when the current test began
    int      test_num;
    int      n_pass;
    int      n_fail;
    string   test_name;
    logic    gaps_on;      // random idle cycles before each access
    cplx_t   tx [4];       // samples of the current vector
    cplx_t   ty [4];       // expected bins of the current vector

    fft4_top u_fft4_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #5 clk = ~clk;   // 100 MHz

    // --------------------
    // bookkeeping
    // --------------------
    task automatic begin_test(input string name);
        test_num++;
        test_name = name;
        test_errs = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == test_errs) begin
            n_pass++;
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            n_fail++;
            $display("test %0d %s: FAIL, %0d errors", test_num, test_name,
                     err_cnt - test_errs);
        end
    endtask

    task automatic check_word(input string what, input wb_dat_t got, input wb_dat_t expected);
        assert (got === expected) else begin
            $display("ERROR %0t: %s: %s expected %h got %h", $time, test_name, what,
                     expected, got);
            err_cnt++;
        end
    endtask

    // --------------------
    // wishbone master
    // --------------------
    task automatic idle_gap();
        int n;
        n = gaps_on ? int'($urandom % 3) : 0;
        repeat (n) @(posedge clk);
    endtask

    // one classic cycle, held until ack, then one idle cycle to catch a stray ack
    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                              output wb_dat_t rdat);
        int   waited;
        logic got;
        idle_gap();
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        waited = 0;
        got    = 1'b0;
        rdat   = '0;
        while (!got && waited < ACK_TIMEOUT) begin
            @(negedge clk);             // ack settled mid cycle
            waited++;
            if (wb_rsp.ack) begin
                got  = 1'b1;
                rdat = wb_rsp.dat;
            end
        end
        @(posedge clk);
        wb_req <= '0;                   // write lands on this edge
        if (!got) begin
            $display("%s: no acknowledge for bus %s at address %0d within %0d cycles",
                     test_name, we ? "write" : "read", adr, ACK_TIMEOUT);
            err_cnt++;
        end else begin
            @(negedge clk);
            assert (!wb_rsp.ack) else begin
                $display("ERROR %0t: %s: second ack at address %0d", $time, test_name, adr);
                err_cnt++;
            end
        end
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t rd_ignored;
        bus_access(1'b1, adr, dat, rd_ignored);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic read_expect(input wb_adr_t adr, input wb_dat_t expected, input string what);
        wb_dat_t rd;
        wb_read(adr, rd);
        check_word(what, rd, expected);
    endtask

    // --------------------
    // transform helpers
    // --------------------
    task automatic wait_done();
        wb_dat_t stat;
        int      polls;
        stat  = '0;
        polls = 0;
        while (!stat[1] && polls < POLL_LIMIT) begin
            wb_read(ADDR_STAT, stat);
            polls++;
        end
        if (!stat[1]) begin
            $display("%s: transform never reported done in %0d status reads", test_name,
                     POLL_LIMIT);
            err_cnt++;
        end else begin
            check_word("STAT after done", stat, 32'h2);   // done set, busy clear
        end
    endtask

    task automatic run_transform(input logic dup_start);
        wb_dat_t rd;
        for (int i = 0; i < 4; i++) begin
            wb_write(ADDR_X0 + wb_adr_t'(i), tx[i]);
        end
        if (dup_start) begin
            gaps_on = 1'b0;             // second start lands inside the busy window
            wb_write(ADDR_CTRL, 32'h1);
            wb_write(ADDR_CTRL, 32'h1); // ignored while busy
            gaps_on = 1'b1;
        end else begin
            wb_write(ADDR_CTRL, 32'h1);
        end
        wait_done();
        for (int i = 0; i < 4; i++) begin
            wb_read(ADDR_Y0 + wb_adr_t'(i), rd);
            check_word($sformatf("Y%0d", i), rd, ty[i]);
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int      fd;
        int      nread;
        int      vec_no;
        string   line;
        wb_dat_t w [8];

        clk       = 1'b0;
        rst_n     = 1'b0;
        wb_req    = '0;
        err_cnt   = 0;
        test_errs = 0;
        test_num  = 0;
        n_pass    = 0;
        n_fail    = 0;
        test_name = "reset";
        gaps_on   = 1'b1;
        vec_no    = 0;
        void'($urandom(32'hbb90));    // seed once for the idle gaps

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset values");
        read_expect(ADDR_STAT, 32'h0, "STAT");
        for (int i = 0; i < 4; i++) begin
            read_expect(ADDR_Y0 + wb_adr_t'(i), 32'h0, $sformatf("Y%0d", i));
        end
        end_test();

        begin_test("sample readback");
        for (int i = 0; i < 4; i++) begin
            wb_write(ADDR_X0 + wb_adr_t'(i), 32'h1357_9bdf + 32'h0101_0101 * i);
        end
        for (int i = 0; i < 4; i++) begin
            read_expect(ADDR_X0 + wb_adr_t'(i), 32'h1357_9bdf + 32'h0101_0101 * i,
                        $sformatf("X%0d", i));
        end
        end_test();

        // one transform per data line, comment lines fail the scan
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", TEST_FILE);
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line  = "";
                nread = $fgets(line, fd);
                nread = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                if (nread == 8) begin
                    vec_no++;
                    for (int i = 0; i < 4; i++) begin
                        tx[i] = w[i];
                        ty[i] = w[i + 4];
                    end
                    begin_test($sformatf("vector %0d", vec_no));
                    run_transform(vec_no % 2 == 0);
                    end_test();
                end
            end
            $fclose(fd);
        end
        if (vec_no == 0) begin
            $display("no test vectors were read from %s", TEST_FILE);
            err_cnt++;
        end

        begin_test("read-only and unmapped");
        for (int i = 0; i < 4; i++) begin
            wb_write(ADDR_Y0 + wb_adr_t'(i), 32'hdead_beef);
        end
        foreach (HOLES[i]) begin
            wb_write(HOLES[i], 32'hffff_ffff);
        end
        for (int i = 0; i < 4; i++) begin
            read_expect(ADDR_Y0 + wb_adr_t'(i), ty[i], $sformatf("Y%0d", i));
            read_expect(ADDR_X0 + wb_adr_t'(i), tx[i], $sformatf("X%0d", i));
        end
        foreach (HOLES[i]) begin
            read_expect(HOLES[i], 32'h0, $sformatf("hole %0d", HOLES[i]));
        end
        read_expect(ADDR_CTRL, 32'h0, "CTRL");
        read_expect(ADDR_STAT, 32'h2, "STAT");   // still done, no start seen
        end_test();

        $display("summary: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, err_cnt);
        if (err_cnt == 0 && n_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/fft4_tests.txt
# columns: x0 x1 x2 x3 then expected y0 y1 y2 y3, each a hex word {re, im}
# rows: dc, impulse, alternating, imag quarter-rate tone, full-scale negative, two random
10000000 10000000 10000000 10000000 0ffe0000 00000000 00000000 00000000
40000000 00000000 00000000 00000000 10000000 10000000 10000000 10000000
20000000 e0000000 20000000 e0000000 ffff0000 00000000 1fff0000 0000ffff
00000000 00004000 00000000 0000c000 00000000 1fff0000 00000000 e0000000
80008000 80008000 80008000 80008000 80008000 ffffffff ffffffff ffffffff
3a7cc915 9e031b6a 5f21e4d8 c6b47f0e ff941218 dded033b 4d39c4dd 0fbfeee2
80017fff 1234edcb 7fff8000 a5a55a5a edf51208 a4dc24dc 1209edf7 db245b22

//--- filelist.f
design/fft4_pkg.sv
design/butterfly.sv
design/fft4_wb_regs.sv
design/fft4_top.sv
sim/fft4_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then scan the log

verilator --binary --assert --timescale 1ns/1ps --top-module fft4_tb \
    -f filelist.f -o fft4_sim > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/fft4_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
